// File: include/axi_sram_defines.svh
`ifndef AXI_SRAM_DEFINES_SVH
`define AXI_SRAM_DEFINES_SVH

// AXI channel field widths
`define AXI_ID_BITS    4    // Transaction ID
`define AXI_ADDR_BITS  32   // Byte address
`define AXI_DATA_BITS  32   // One word per beat
`define AXI_STRB_BITS  4    // One strobe per byte lane
`define AXI_LEN_BITS   4    // Up to 16 beats
`define AXI_SIZE_BITS  3    // Bytes per beat as a power of two

// SRAM geometry
`define SRAM_WORDS     1024 // Depth in words
`define SRAM_ADDR_BITS 10   // Word index, log2 of depth

// Must agree with the two above
// Byte address bits 1:0 select the lane inside a word
// Index taken from byte address bits 11:2

`endif

// File: verilog/axi_sram_pkg.sv
`include "axi_sram_defines.svh"

package axi_sram_pkg;

    // AXI burst encoding, 2'b11 reserved
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10  // Handled as INCR here
    } burst_t;

    typedef enum logic [1:0] {
        WR_IDLE = 2'b00, // Waiting for aw
        WR_DATA = 2'b01, // Taking w beats
        WR_RESP = 2'b10  // Holding b until accepted
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE  = 2'b00, // Waiting for ar
        RD_FETCH = 2'b01, // SRAM read issued
        RD_DATA  = 2'b10  // Beat presented on r
    } rd_state_t;

    // Shared by aw and ar
    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_LEN_BITS-1:0]  len;   // Beats minus one
        logic [`AXI_SIZE_BITS-1:0] size;
        burst_t                    burst;
    } aw_req_t;

    typedef struct packed {
        logic [`AXI_DATA_BITS-1:0] data;
        logic [`AXI_STRB_BITS-1:0] strb;
        logic                      last;
    } w_beat_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0] id;
        logic [1:0]              resp;  // Always OKAY
    } b_rsp_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_DATA_BITS-1:0] data;
        logic [1:0]                resp; // Always OKAY
        logic                      last;
    } r_beat_t;

    // One strobed word write into the bank
    typedef struct packed {
        logic [`SRAM_ADDR_BITS-1:0] index;
        logic [`AXI_DATA_BITS-1:0]  data;
        logic [`AXI_STRB_BITS-1:0]  be;    // Byte lane enables
    } mem_wr_t;

endpackage

// File: verilog/burst_addr_gen.sv
`timescale 1ns/100ps
`include "axi_sram_defines.svh"

module burst_addr_gen (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       load,       // Start of burst
    input  axi_sram_pkg::aw_req_t      req,
    input  logic                       step,       // One beat consumed
    output logic [`SRAM_ADDR_BITS-1:0] word_index,
    output logic                       last_beat
);

    // Byte offset inside the bank, two extra bits below the word index
    localparam int OFFS_BITS = `SRAM_ADDR_BITS + 2;

    logic [OFFS_BITS-1:0]      addr_q;  // Current byte offset
    axi_sram_pkg::burst_t      burst_q;
    logic [`AXI_SIZE_BITS-1:0] size_q;
    logic [`AXI_LEN_BITS-1:0]  count_q; // Beats left after this one
    logic [OFFS_BITS-1:0]      incr;

    assign incr = OFFS_BITS'(1) << size_q; // 2**size bytes per beat

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            addr_q  <= '0;
            burst_q <= axi_sram_pkg::BURST_FIXED;
            size_q  <= '0;
            count_q <= '0;
        end else if (load) begin
            addr_q  <= req.addr[OFFS_BITS-1:0]; // Upper bits dropped, modulo depth
            burst_q <= req.burst;
            size_q  <= req.size;
            count_q <= req.len;
        end else if (step) begin
            // FIXED stays put, INCR, WRAP and reserved all advance
            if (burst_q != axi_sram_pkg::BURST_FIXED)
                addr_q <= addr_q + incr;
            if (count_q != '0)
                count_q <= count_q - 1'b1; // Saturate at the final beat
        end
    end

    assign word_index = addr_q[OFFS_BITS-1:2];
    assign last_beat  = (count_q == '0);

endmodule

// File: verilog/sram_bank.sv
`timescale 1ns/100ps
`include "axi_sram_defines.svh"

module sram_bank (
    input  logic                       clock,
    input  logic                       wr_en,
    input  axi_sram_pkg::mem_wr_t      wr,
    input  logic                       rd_en,
    input  logic [`SRAM_ADDR_BITS-1:0] rd_index,
    output logic [`AXI_DATA_BITS-1:0]  rd_data
);

    // Word array, contents undefined after power up
    logic [`AXI_DATA_BITS-1:0] mem [`SRAM_WORDS];

    // Write port, one byte lane per strobe bit
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int lane = 0; lane < `AXI_STRB_BITS; lane++) begin
                if (wr.be[lane])
                    mem[wr.index][8*lane +: 8] <= wr.data[8*lane +: 8];
            end
        end
    end

    // Registered read port
    // Same word written on the same edge reads the old value
    // Output holds while rd_en is low
    always_ff @(posedge clock) begin
        if (rd_en)
            rd_data <= mem[rd_index];
    end

endmodule

// File: verilog/axi_write_ctrl.sv
`timescale 1ns/100ps
`include "axi_sram_defines.svh"

module axi_write_ctrl (
    input  logic                  clock,
    input  logic                  reset,
    input  axi_sram_pkg::aw_req_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_sram_pkg::w_beat_t w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axi_sram_pkg::b_rsp_t  b,
    output logic                  b_valid,
    input  logic                  b_ready,
    output logic                  mem_wr_en,
    output axi_sram_pkg::mem_wr_t mem_wr
);

    axi_sram_pkg::wr_state_t    state;
    axi_sram_pkg::wr_state_t    state_next;
    logic [`AXI_ID_BITS-1:0]    id_q;     // Burst ID for the response
    logic [`SRAM_ADDR_BITS-1:0] wr_index; // Word of the current beat
    logic                       aw_fire;
    logic                       w_fire;
    logic                       b_fire;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    // Burst ends on w.last, beat count not checked
    burst_addr_gen u_addr_gen (
        .clock      (clock),
        .reset      (reset),
        .load       (aw_fire),
        .req        (aw),
        .step       (w_fire),
        .word_index (wr_index),
        .last_beat  ()
    );

    always_comb begin
        state_next = state;
        case (state)
            axi_sram_pkg::WR_IDLE:
                if (aw_fire)
                    state_next = axi_sram_pkg::WR_DATA;
            axi_sram_pkg::WR_DATA:
                if (w_fire && w.last)
                    state_next = axi_sram_pkg::WR_RESP;
            axi_sram_pkg::WR_RESP:
                if (b_fire)
                    state_next = axi_sram_pkg::WR_IDLE; // Only stall point
            default:
                state_next = axi_sram_pkg::WR_IDLE;
        endcase
    end

    // Handshake flags follow the next state, all low in reset
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= axi_sram_pkg::WR_IDLE;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            state    <= state_next;
            aw_ready <= (state_next == axi_sram_pkg::WR_IDLE);
            w_ready  <= (state_next == axi_sram_pkg::WR_DATA);
            b_valid  <= (state_next == axi_sram_pkg::WR_RESP);
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire)
            id_q <= aw.id;
    end

    // Each accepted beat is written on the same edge
    assign mem_wr_en = w_fire;

    always_comb begin
        mem_wr.index = wr_index;
        mem_wr.data  = w.data;
        mem_wr.be    = w.strb; // Strobes map straight onto byte lanes
    end

    assign b = '{id: id_q, resp: 2'b00}; // OKAY

endmodule

// File: verilog/axi_read_ctrl.sv
`timescale 1ns/100ps
`include "axi_sram_defines.svh"

module axi_read_ctrl (
    input  logic                       clock,
    input  logic                       reset,
    input  axi_sram_pkg::aw_req_t      ar,
    input  logic                       ar_valid,
    output logic                       ar_ready,
    output axi_sram_pkg::r_beat_t      r,
    output logic                       r_valid,
    input  logic                       r_ready,
    output logic                       mem_rd_en,
    output logic [`SRAM_ADDR_BITS-1:0] mem_rd_index,
    input  logic [`AXI_DATA_BITS-1:0]  mem_rd_data
);

    axi_sram_pkg::rd_state_t state;
    axi_sram_pkg::rd_state_t state_next;
    logic [`AXI_ID_BITS-1:0] id_q;      // Echoed on every beat
    logic                    last_beat; // Final beat of the burst
    logic                    ar_fire;
    logic                    r_fire;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;

    burst_addr_gen u_addr_gen (
        .clock      (clock),
        .reset      (reset),
        .load       (ar_fire),
        .req        (ar),
        .step       (r_fire),     // Advance once the beat is taken
        .word_index (mem_rd_index),
        .last_beat  (last_beat)
    );

    always_comb begin
        state_next = state;
        case (state)
            axi_sram_pkg::RD_IDLE:
                if (ar_fire)
                    state_next = axi_sram_pkg::RD_FETCH;
            axi_sram_pkg::RD_FETCH:
                state_next = axi_sram_pkg::RD_DATA; // Data lands next cycle
            axi_sram_pkg::RD_DATA:
                if (r_fire)
                    state_next = last_beat ? axi_sram_pkg::RD_IDLE
                                           : axi_sram_pkg::RD_FETCH;
            default:
                state_next = axi_sram_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= axi_sram_pkg::RD_IDLE;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            state    <= state_next;
            ar_ready <= (state_next == axi_sram_pkg::RD_IDLE);
            r_valid  <= (state_next == axi_sram_pkg::RD_DATA);
        end
    end

    always_ff @(posedge clock) begin
        if (ar_fire)
            id_q <= ar.id;
    end

    assign mem_rd_en = (state == axi_sram_pkg::RD_FETCH); // One read per beat

    // Bank output holds while stalled, so the beat stays stable
    assign r = '{id: id_q, data: mem_rd_data, resp: 2'b00, last: last_beat};

endmodule

// File: verilog/axi_sram_slave.sv
`timescale 1ns/100ps
`include "axi_sram_defines.svh"

module axi_sram_slave (
    input  logic                  clock,
    input  logic                  reset,
    // Write address
    input  axi_sram_pkg::aw_req_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    // Write data
    input  axi_sram_pkg::w_beat_t w,
    input  logic                  w_valid,
    output logic                  w_ready,
    // Write response
    output axi_sram_pkg::b_rsp_t  b,
    output logic                  b_valid,
    input  logic                  b_ready,
    // Read address, same layout as aw
    input  axi_sram_pkg::aw_req_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    // Read data
    output axi_sram_pkg::r_beat_t r,
    output logic                  r_valid,
    input  logic                  r_ready
);

    logic                       mem_wr_en;
    axi_sram_pkg::mem_wr_t      mem_wr;
    logic                       mem_rd_en;
    logic [`SRAM_ADDR_BITS-1:0] mem_rd_index;
    logic [`AXI_DATA_BITS-1:0]  mem_rd_data;

    axi_write_ctrl u_write_ctrl (
        .clock     (clock),
        .reset     (reset),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .mem_wr_en (mem_wr_en),
        .mem_wr    (mem_wr)
    );

    axi_read_ctrl u_read_ctrl (
        .clock        (clock),
        .reset        (reset),
        .ar           (ar),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .r            (r),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_index (mem_rd_index),
        .mem_rd_data  (mem_rd_data)
    );

    // Independent write and read ports, no arbitration needed
    sram_bank u_sram_bank (
        .clock    (clock),
        .wr_en    (mem_wr_en),
        .wr       (mem_wr),
        .rd_en    (mem_rd_en),
        .rd_index (mem_rd_index),
        .rd_data  (mem_rd_data)
    );

endmodule

// File: bench/axi_sram_props.sv
`timescale 1ns/100ps

module axi_sram_props (
    input logic                  clock,
    input logic                  reset,
    input logic                  aw_ready,
    input logic                  b_valid,
    input logic                  b_ready,
    input logic                  r_valid,
    input logic                  r_ready,
    input axi_sram_pkg::r_beat_t r
);

    int fail_count = 0; // Read by the testbench at the end of the run

    // Response held until the master takes it
    b_hold: assert property (@(posedge clock) disable iff (!reset)
        b_valid && !b_ready |=> b_valid)
        else begin
            $error("b_valid dropped before b_ready");
            fail_count++;
        end

    // Read beat frozen under back-pressure
    r_hold: assert property (@(posedge clock) disable iff (!reset)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            $error("r beat changed while r_ready was low");
            fail_count++;
        end

    // No new burst while a response is pending
    aw_blocked: assert property (@(posedge clock) disable iff (!reset)
        b_valid |-> !aw_ready)
        else begin
            $error("aw_ready high with b_valid pending");
            fail_count++;
        end

    // First cycle out of reset
    quiet_start: assert property (@(posedge clock) $rose(reset) |-> !b_valid && !r_valid)
        else begin
            $error("valid high right after reset");
            fail_count++;
        end

endmodule

bind axi_sram_slave axi_sram_props props (
    .clock    (clock),
    .reset    (reset),
    .aw_ready (aw_ready),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r)
);

// File: bench/tb_axi_sram.sv
`timescale 1ns/100ps
`include "axi_sram_defines.svh"

module tb_axi_sram;

    localparam int TIMEOUT = 100; // Cycles per handshake wait

    logic                  clock;
    logic                  reset;
    axi_sram_pkg::aw_req_t aw;
    logic                  aw_valid;
    logic                  aw_ready;
    axi_sram_pkg::w_beat_t w;
    logic                  w_valid;
    logic                  w_ready;
    axi_sram_pkg::b_rsp_t  b;
    logic                  b_valid;
    logic                  b_ready;
    axi_sram_pkg::aw_req_t ar;
    logic                  ar_valid;
    logic                  ar_ready;
    axi_sram_pkg::r_beat_t r;
    logic                  r_valid;
    logic                  r_ready;

    integer                    seed;
    int                        errors;
    int                        cnt;
    logic [`AXI_DATA_BITS-1:0] ref_mem [`SRAM_WORDS]; // Expected SRAM contents
    logic [`AXI_DATA_BITS-1:0] beat_data [16];        // Next write burst payload
    logic [`AXI_STRB_BITS-1:0] beat_strb [16];
    logic [`AXI_ADDR_BITS-1:0] addr_list [4];
    logic [`AXI_ID_BITS-1:0]   id_list [4];
    logic [`AXI_ADDR_BITS-1:0] base;
    axi_sram_pkg::r_beat_t     exp_r_q [$]; // Beats still owed on r
    axi_sram_pkg::b_rsp_t      exp_b_q [$];
    axi_sram_pkg::r_beat_t     exp_r;
    axi_sram_pkg::b_rsp_t      exp_b;

    axi_sram_slave dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Byte address to word index, size fixed at 4 bytes
    function automatic int word_of(input logic [31:0] addr, input axi_sram_pkg::burst_t kind,
                                   input int beat);
        logic [31:0] byte_addr;
        byte_addr = addr;
        if (kind != axi_sram_pkg::BURST_FIXED)
            byte_addr = addr + 32'(4 * beat); // INCR, WRAP and reserved all step
        return int'((byte_addr >> 2) % `SRAM_WORDS);
    endfunction

    // Reference model, strobed bytes replaced and the rest kept
    function automatic void model_write(input logic [31:0] addr, input axi_sram_pkg::burst_t kind,
                                        input int beat, input logic [31:0] data,
                                        input logic [3:0] strb);
        int idx;
        idx = word_of(addr, kind, beat);
        for (int lane = 0; lane < `AXI_STRB_BITS; lane++) begin
            if (strb[lane])
                ref_mem[idx][8*lane +: 8] = data[8*lane +: 8];
        end
    endfunction

    task automatic abort_run(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Errors: %0d", errors + 1);
        $display("Checks failed");
        $finish;
    endtask

    // b_stall holds b_ready low for that many cycles once b_valid is up
    task automatic write_burst(input logic [3:0] tid, input logic [31:0] start,
                               input axi_sram_pkg::burst_t kind, input int beats,
                               input int b_stall = 0);
        int wait_cnt;
        @(posedge clock);
        aw       <= '{id: tid, addr: start, len: 4'(beats - 1), size: 3'd2, burst: kind};
        aw_valid <= 1'b1;
        wait_cnt = 0;
        do begin
            @(negedge clock);
            wait_cnt++;
        end while (!aw_ready && wait_cnt < TIMEOUT);
        if (!aw_ready)
            abort_run("aw_ready");
        @(posedge clock); // aw transfer
        aw_valid <= 1'b0;
        for (int n = 0; n < beats; n++) begin
            w       <= '{data: beat_data[n], strb: beat_strb[n], last: (n == beats - 1)};
            w_valid <= 1'b1;
            wait_cnt = 0;
            do begin
                @(negedge clock);
                wait_cnt++;
            end while (!w_ready && wait_cnt < TIMEOUT);
            if (!w_ready)
                abort_run("w_ready");
            model_write(start, kind, n, beat_data[n], beat_strb[n]);
            @(posedge clock); // w transfer
        end
        w_valid <= 1'b0;
        b_ready <= (b_stall == 0);
        exp_b_q.push_back('{id: tid, resp: 2'b00});
        wait_cnt = 0;
        do begin
            @(negedge clock);
            wait_cnt++;
        end while (!b_valid && wait_cnt < TIMEOUT);
        if (!b_valid)
            abort_run("b_valid");
        if (b_stall > 0) begin
            repeat (b_stall) begin
                @(negedge clock);
                if (!b_valid) begin
                    $display("Error at %0t: b_valid dropped while b_ready was low", $time);
                    errors++;
                end
            end
            @(posedge clock);
            b_ready <= 1'b1;
            @(negedge clock);
        end
        @(posedge clock); // b transfer
    endtask

    // stall holds r_ready low for that many cycles on the first beat
    task automatic read_burst(input logic [3:0] tid, input logic [31:0] start,
                              input axi_sram_pkg::burst_t kind, input int beats, input int stall);
        int                    wait_cnt;
        axi_sram_pkg::r_beat_t held;
        @(posedge clock);
        ar       <= '{id: tid, addr: start, len: 4'(beats - 1), size: 3'd2, burst: kind};
        ar_valid <= 1'b1;
        r_ready  <= (stall == 0);
        wait_cnt = 0;
        do begin
            @(negedge clock);
            wait_cnt++;
        end while (!ar_ready && wait_cnt < TIMEOUT);
        if (!ar_ready)
            abort_run("ar_ready");
        @(posedge clock); // ar transfer
        ar_valid <= 1'b0;
        for (int n = 0; n < beats; n++) begin
            exp_r_q.push_back('{id: tid, data: ref_mem[word_of(start, kind, n)], resp: 2'b00,
                                last: (n == beats - 1)});
            wait_cnt = 0;
            do begin
                @(negedge clock);
                wait_cnt++;
            end while (!r_valid && wait_cnt < TIMEOUT);
            if (!r_valid)
                abort_run("r_valid");
            if (wait_cnt != 2) begin // Fetch cycle then data cycle
                $display("Error at %0t: r_valid %0d cycles after handshake, expected 2",
                         $time, wait_cnt);
                errors++;
            end
            if (n == 0 && stall > 0) begin
                held = r;
                repeat (stall) begin
                    @(negedge clock);
                    if (!r_valid || r !== held) begin
                        $display("Error at %0t: r beat not held under stall", $time);
                        errors++;
                    end
                end
                @(posedge clock);
                r_ready <= 1'b1;
                @(negedge clock);
            end
            @(posedge clock); // r transfer
        end
    endtask

    // Checker, a transfer seen at negedge completes on the next rising edge
    always @(negedge clock) begin
        if (reset && r_valid && r_ready) begin
            if (exp_r_q.size() == 0) begin
                $display("Error at %0t: r beat with no read outstanding", $time);
                errors++;
            end else begin
                exp_r = exp_r_q.pop_front();
                if (r !== exp_r) begin
                    $display("Error at %0t: r id %h data %h resp %b last %b, exp %h %h %b %b",
                             $time, r.id, r.data, r.resp, r.last,
                             exp_r.id, exp_r.data, exp_r.resp, exp_r.last);
                    errors++;
                end
            end
        end
        if (reset && b_valid && b_ready) begin
            if (exp_b_q.size() == 0) begin
                $display("Error at %0t: b response with no write outstanding", $time);
                errors++;
            end else begin
                exp_b = exp_b_q.pop_front();
                if (b !== exp_b) begin
                    $display("Error at %0t: b id %h resp %b, expected id %h resp %b",
                             $time, b.id, b.resp, exp_b.id, exp_b.resp);
                    errors++;
                end
            end
        end
    end

    initial begin
        seed     = 84;
        errors   = 0;
        reset    = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b1;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b1;
        repeat (10) begin
            @(negedge clock);
            if (b_valid || r_valid || aw_ready || ar_ready || w_ready) begin
                $display("Error at %0t: handshake output high during reset", $time);
                errors++;
            end
        end
        @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        if (b_valid || r_valid) begin
            $display("Error at %0t: valid high on first cycle after reset", $time);
            errors++;
        end
        cnt = 0;
        while (!(aw_ready && ar_ready) && cnt < TIMEOUT) begin
            @(negedge clock);
            cnt++;
        end
        if (!(aw_ready && ar_ready))
            abort_run("aw_ready and ar_ready after reset");

        // Single full-strobe beats to random words
        for (int k = 0; k < 4; k++) begin
            addr_list[k] = $random(seed) & 32'hffff_fffc;
            id_list[k]   = $random(seed);
            beat_data[0] = $random(seed);
            beat_strb[0] = 4'hf;
            write_burst(id_list[k], addr_list[k], axi_sram_pkg::BURST_INCR, 1);
        end
        for (int k = 0; k < 4; k++)
            read_burst(id_list[k], addr_list[k], axi_sram_pkg::BURST_INCR, 1, 0);

        // Four-beat INCR round trip, response held off for a few cycles
        base = $random(seed) & 32'hffff_fffc;
        for (int n = 0; n < 4; n++) begin
            beat_data[n] = $random(seed);
            beat_strb[n] = 4'hf;
        end
        write_burst(4'h3, base, axi_sram_pkg::BURST_INCR, 4, 3);
        read_burst(4'h5, base, axi_sram_pkg::BURST_INCR, 4, 0);

        // Partial strobe over a known word
        base         = $random(seed) & 32'hffff_fffc;
        beat_data[0] = 32'h1122_3344;
        beat_strb[0] = 4'hf;
        write_burst(4'h7, base, axi_sram_pkg::BURST_INCR, 1);
        beat_data[0] = $random(seed);
        beat_strb[0] = 4'b0101;
        write_burst(4'h8, base, axi_sram_pkg::BURST_INCR, 1);
        read_burst(4'h9, base, axi_sram_pkg::BURST_INCR, 1, 0);

        // FIXED burst onto one word between two known neighbours
        base = $random(seed) & 32'hffff_fffc;
        for (int n = 0; n < 3; n++) begin
            beat_data[n] = $random(seed);
            beat_strb[n] = 4'hf;
        end
        write_burst(4'ha, base - 32'd4, axi_sram_pkg::BURST_INCR, 3);
        beat_strb[0] = 4'b0011;
        beat_strb[1] = 4'b0110;
        beat_strb[2] = 4'b1000;
        for (int n = 0; n < 3; n++)
            beat_data[n] = $random(seed);
        write_burst(4'hb, base, axi_sram_pkg::BURST_FIXED, 3);
        read_burst(4'hc, base - 32'd4, axi_sram_pkg::BURST_INCR, 3, 0);

        // Back-pressure on r
        read_burst(4'hd, base - 32'd4, axi_sram_pkg::BURST_INCR, 3, 5);

        repeat (5) @(posedge clock);
        if (exp_r_q.size() != 0 || exp_b_q.size() != 0) begin
            $display("Responses missing at end of run: %0d r beats, %0d b responses",
                     exp_r_q.size(), exp_b_q.size());
            errors++;
        end
        errors += dut.props.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
verilog/axi_sram_pkg.sv
verilog/burst_addr_gen.sv
verilog/sram_bank.sv
verilog/axi_write_ctrl.sv
verilog/axi_read_ctrl.sv
verilog/axi_sram_slave.sv
bench/axi_sram_props.sv
bench/tb_axi_sram.sv

// File: Bender.yml
package:
  name: axi_sram_slave

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/axi_sram_pkg.sv
      - verilog/burst_addr_gen.sv
      - verilog/sram_bank.sv
      - verilog/axi_write_ctrl.sv
      - verilog/axi_read_ctrl.sv
      - verilog/axi_sram_slave.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/axi_sram_props.sv
      - bench/tb_axi_sram.sv
